// File: source/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int ADDR_W     = XLEN - 2;  // word address
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int ALU_OP_W   = 4;

    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;  // addi x0,x0,0

    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'b0000;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'b0001;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 4'b0010;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 4'b0011;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'b0100;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'b0101;
    localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'b0110;
    localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'b0111;
    localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'b1000;

    typedef logic [1:0] fwd_sel_t;
    localparam fwd_sel_t FWD_NONE   = 2'd0;
    localparam fwd_sel_t FWD_EX_MEM = 2'd1;
    localparam fwd_sel_t FWD_MEM_WB = 2'd2;

    // register-form view of an instruction word
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fields_t;

    // store-form view with imm[4:0] in the rd bits
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fields_t;

    typedef union packed {
        r_fields_t r;
        s_fields_t s;
    } inst_u;

    typedef struct packed {
        logic [ALU_OP_W-1:0] alu_op;
        logic                alu_src_imm;
        logic                link_pc;       // result is pc+4
        logic                is_branch_ne;
    } ex_ctrl_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
    } mem_ctrl_t;

    typedef struct packed {
        logic mem_to_reg;
        logic reg_write;
    } wb_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  is_branch;
        ex_ctrl_t              ex_ctrl;
        mem_ctrl_t             mem_ctrl;
        wb_ctrl_t              wb_ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       alu_out;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        mem_ctrl_t             mem_ctrl;
        wb_ctrl_t              wb_ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]       alu_out;
        logic [XLEN-1:0]       load_data;
        logic [REG_ADDR_W-1:0] rd;
        wb_ctrl_t              wb_ctrl;
    } mem_wb_t;

    typedef struct packed {
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic              ren;
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   wdata;
    } dmem_req_t;

endpackage

// File: source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [rv_pkg::XLEN-1:0]    i_inst_word,
    output logic [rv_pkg::ADDR_W-1:0]  o_imem_addr,
    input  logic                       i_hold,        // data-memory stall
    input  logic                       i_load_use,
    input  logic                       i_redirect,
    input  logic [rv_pkg::XLEN-1:0]    i_redirect_pc,
    output rv_pkg::if_id_t             o_if_id
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] pc_next;
    inst_u           fetched;
    logic            is_jal;

    assign fetched     = i_inst_word;
    assign o_imem_addr = pc_q[XLEN-1:2];

    // jal predecode straight from the fetched word
    assign is_jal = (fetched.r.opcode == OP_JAL);
    assign j_imm  = {{12{i_inst_word[31]}}, i_inst_word[19:12], i_inst_word[20],
                     i_inst_word[30:21], 1'b0};
    assign pc_next = is_jal ? pc_q + j_imm : pc_q + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q         <= '0;
            o_if_id.pc   <= '0;
            o_if_id.inst <= NOP_INST;
        end else if (!i_hold) begin
            if (i_redirect) begin
                pc_q         <= i_redirect_pc;
                o_if_id.inst <= NOP_INST;  // squash wrong-path word
            end else if (!i_load_use) begin
                pc_q         <= pc_next;
                o_if_id.pc   <= pc_q;
                o_if_id.inst <= fetched;   // jal goes on for its link write
            end
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  rv_pkg::if_id_t i_if_id,
    input  rv_pkg::wb_t    i_wb,
    input  logic           i_hold,
    input  logic           i_load_use,
    input  logic           i_redirect,
    output rv_pkg::id_ex_t o_id_ex
);
    import rv_pkg::*;

    logic [XLEN-1:0]     regs [NUM_REGS];
    inst_u               inst;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_s;
    logic [XLEN-1:0]     imm_b;
    logic [XLEN-1:0]     imm_j;
    logic [ALU_OP_W-1:0] alu_op;
    id_ex_t              id_ex_n;

    // x0 reads zero and a register being written reads the writeback data
    function automatic logic [XLEN-1:0] rf_read(input logic [REG_ADDR_W-1:0] a,
                                                input logic [XLEN-1:0] stored,
                                                input wb_t wb);
        if (a == '0)
            return '0;
        else if (wb.reg_write && wb.rd == a)
            return wb.data;
        else
            return stored;
    endfunction

    assign inst = i_if_id.inst;

    assign imm_i = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{20{inst.s.imm_hi[6]}}, inst.s.imm_lo[0], inst.s.imm_hi[5:0],
                    inst.s.imm_lo[4:1], 1'b0};
    assign imm_j = {{12{inst.r.funct7[6]}}, inst.r.rs1, inst.r.funct3, inst.r.rs2[0],
                    inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};

    always_comb begin
        alu_op = ALU_ADD;  // loads, stores, jal
        if (inst.r.opcode == OP_RTYPE || inst.r.opcode == OP_ITYPE) begin
            case (inst.r.funct3)
                3'b000: alu_op = (inst.r.opcode == OP_RTYPE && inst.r.funct7[5]) ?
                                 ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: alu_op = ALU_OR;
                3'b111: alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        id_ex_n          = '0;
        id_ex_n.pc       = i_if_id.pc;
        id_ex_n.imm      = imm_i;
        id_ex_n.rs1      = inst.r.rs1;
        id_ex_n.rs2      = inst.r.rs2;
        id_ex_n.rd       = inst.r.rd;
        id_ex_n.rs1_data = rf_read(inst.r.rs1, regs[inst.r.rs1], i_wb);
        id_ex_n.rs2_data = rf_read(inst.r.rs2, regs[inst.r.rs2], i_wb);
        id_ex_n.ex_ctrl.alu_op = alu_op;
        case (inst.r.opcode)
            OP_RTYPE: id_ex_n.wb_ctrl.reg_write = 1'b1;
            OP_ITYPE: begin
                id_ex_n.ex_ctrl.alu_src_imm = 1'b1;
                id_ex_n.wb_ctrl.reg_write   = 1'b1;
            end
            OP_LOAD: begin
                id_ex_n.ex_ctrl.alu_src_imm = 1'b1;
                id_ex_n.mem_ctrl.mem_read   = 1'b1;
                id_ex_n.wb_ctrl.mem_to_reg  = 1'b1;
                id_ex_n.wb_ctrl.reg_write   = 1'b1;
            end
            OP_STORE: begin
                id_ex_n.imm                 = imm_s;
                id_ex_n.ex_ctrl.alu_src_imm = 1'b1;
                id_ex_n.mem_ctrl.mem_write  = 1'b1;
            end
            OP_BRANCH: begin
                id_ex_n.imm                  = imm_b;
                id_ex_n.is_branch            = 1'b1;
                id_ex_n.ex_ctrl.is_branch_ne = inst.r.funct3[0];  // bne
            end
            OP_JAL: begin
                id_ex_n.imm               = imm_j;
                id_ex_n.ex_ctrl.link_pc   = 1'b1;
                id_ex_n.wb_ctrl.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    // register file holds with the pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (!i_hold && i_wb.reg_write && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_id_ex <= '0;
        end else if (!i_hold) begin
            if (i_load_use || i_redirect)
                o_id_ex <= '0;  // bubble
            else
                o_id_ex <= id_ex_n;
        end
    end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_pkg::id_ex_t          i_id_ex,
    input  logic [rv_pkg::XLEN-1:0] i_ex_mem_alu,
    input  rv_pkg::wb_t             i_wb,
    input  rv_pkg::fwd_sel_t        i_fwd_a,
    input  rv_pkg::fwd_sel_t        i_fwd_b,
    input  logic                    i_hold,
    output logic                    o_redirect,
    output logic [rv_pkg::XLEN-1:0] o_redirect_pc,
    output rv_pkg::ex_mem_t         o_ex_mem
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] alu_out;
    logic [4:0]      shamt;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_t sel,
                                                input logic [XLEN-1:0] reg_val,
                                                input logic [XLEN-1:0] ex_mem_val,
                                                input logic [XLEN-1:0] wb_val);
        case (sel)
            FWD_EX_MEM: return ex_mem_val;
            FWD_MEM_WB: return wb_val;
            default:    return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(i_fwd_a, i_id_ex.rs1_data, i_ex_mem_alu, i_wb.data);
    assign op_b  = fwd_mux(i_fwd_b, i_id_ex.rs2_data, i_ex_mem_alu, i_wb.data);
    assign alu_b = i_id_ex.ex_ctrl.alu_src_imm ? i_id_ex.imm : op_b;
    assign diff  = op_a - alu_b;
    assign shamt = alu_b[4:0];

    always_comb begin
        if (i_id_ex.ex_ctrl.link_pc) begin
            alu_out = i_id_ex.pc + 32'd4;  // jal link
        end else begin
            case (i_id_ex.ex_ctrl.alu_op)
                ALU_ADD: alu_out = op_a + alu_b;
                ALU_SUB: alu_out = diff;
                ALU_AND: alu_out = op_a & alu_b;
                ALU_OR:  alu_out = op_a | alu_b;
                ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
                ALU_XOR: alu_out = op_a ^ alu_b;
                ALU_SLL: alu_out = op_a << shamt;
                ALU_SRA: alu_out = $unsigned($signed(op_a) >>> shamt);
                ALU_SRL: alu_out = op_a >> shamt;
                default: alu_out = op_a + alu_b;
            endcase
        end
    end

    // beq/bne resolved on the forwarded operands
    assign o_redirect    = i_id_ex.is_branch &&
                           ((op_a == op_b) ^ i_id_ex.ex_ctrl.is_branch_ne);
    assign o_redirect_pc = i_id_ex.pc + i_id_ex.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ex_mem <= '0;
        end else if (!i_hold) begin
            o_ex_mem.alu_out    <= alu_out;
            o_ex_mem.store_data <= op_b;
            o_ex_mem.rd         <= i_id_ex.rd;
            o_ex_mem.mem_ctrl   <= i_id_ex.mem_ctrl;
            o_ex_mem.wb_ctrl    <= i_id_ex.wb_ctrl;
        end
    end

endmodule

// File: source/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_pkg::ex_mem_t         i_ex_mem,
    input  logic [rv_pkg::XLEN-1:0] i_dmem_rdata,
    input  logic                    i_hold,
    output rv_pkg::dmem_req_t       o_dmem,
    output rv_pkg::wb_t             o_wb
);
    import rv_pkg::*;

    mem_wb_t mem_wb;

    // request comes straight from EX/MEM and holds with it
    assign o_dmem.ren   = i_ex_mem.mem_ctrl.mem_read;
    assign o_dmem.wen   = i_ex_mem.mem_ctrl.mem_write;
    assign o_dmem.addr  = i_ex_mem.alu_out[XLEN-1:2];
    assign o_dmem.wdata = i_ex_mem.store_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (!i_hold) begin
            mem_wb.alu_out   <= i_ex_mem.alu_out;
            mem_wb.load_data <= i_dmem_rdata;  // valid on the unstalled edge
            mem_wb.rd        <= i_ex_mem.rd;
            mem_wb.wb_ctrl   <= i_ex_mem.wb_ctrl;
        end
    end

    assign o_wb.reg_write = mem_wb.wb_ctrl.reg_write;
    assign o_wb.rd        = mem_wb.rd;
    assign o_wb.data      = mem_wb.wb_ctrl.mem_to_reg ? mem_wb.load_data : mem_wb.alu_out;

endmodule

// File: source/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::if_id_t   i_if_id,
    input  rv_pkg::id_ex_t   i_id_ex,
    input  rv_pkg::ex_mem_t  i_ex_mem,
    input  rv_pkg::wb_t      i_wb,
    output rv_pkg::fwd_sel_t o_fwd_a,
    output rv_pkg::fwd_sel_t o_fwd_b,
    output logic             o_load_use
);
    import rv_pkg::*;

    logic [REG_ADDR_W-1:0] ld_rd;
    logic                  ld_in_ex;

    // youngest producer wins
    function automatic fwd_sel_t fwd_select(input logic [REG_ADDR_W-1:0] rs,
                                            input ex_mem_t ex_mem,
                                            input wb_t wb);
        if (rs == '0)
            return FWD_NONE;
        else if (ex_mem.wb_ctrl.reg_write && ex_mem.rd == rs)
            return FWD_EX_MEM;
        else if (wb.reg_write && wb.rd == rs)
            return FWD_MEM_WB;
        else
            return FWD_NONE;
    endfunction

    assign o_fwd_a = fwd_select(i_id_ex.rs1, i_ex_mem, i_wb);
    assign o_fwd_b = fwd_select(i_id_ex.rs2, i_ex_mem, i_wb);

    // load in ID/EX against both source fields of the IF/ID word
    assign ld_rd      = i_id_ex.rd;
    assign ld_in_ex   = i_id_ex.mem_ctrl.mem_read && ld_rd != '0;
    assign o_load_use = ld_in_ex && (ld_rd == i_if_id.inst.r.rs1 ||
                                     ld_rd == i_if_id.inst.r.rs2);

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [rv_pkg::XLEN-1:0]    i_imem_rdata,
    output logic [rv_pkg::ADDR_W-1:0]  o_imem_addr,
    output rv_pkg::dmem_req_t          o_dmem,
    input  logic [rv_pkg::XLEN-1:0]    i_dmem_rdata,
    input  logic                       i_dmem_stall
);
    import rv_pkg::*;

    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    wb_t             wb;
    fwd_sel_t        fwd_a;
    fwd_sel_t        fwd_b;
    logic            load_use;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    fetch_stage fetch_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_inst_word   (i_imem_rdata),
        .o_imem_addr   (o_imem_addr),
        .i_hold        (i_dmem_stall),
        .i_load_use    (load_use),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_if_id       (if_id)
    );

    decode_stage decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_if_id    (if_id),
        .i_wb       (wb),
        .i_hold     (i_dmem_stall),
        .i_load_use (load_use),
        .i_redirect (redirect),
        .o_id_ex    (id_ex)
    );

    execute_stage execute_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_id_ex       (id_ex),
        .i_ex_mem_alu  (ex_mem.alu_out),
        .i_wb          (wb),
        .i_fwd_a       (fwd_a),
        .i_fwd_b       (fwd_b),
        .i_hold        (i_dmem_stall),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_ex_mem      (ex_mem)
    );

    memory_stage memory_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ex_mem     (ex_mem),
        .i_dmem_rdata (i_dmem_rdata),
        .i_hold       (i_dmem_stall),
        .o_dmem       (o_dmem),
        .o_wb         (wb)
    );

    hazard_unit hazard_i (
        .i_if_id    (if_id),
        .i_id_ex    (id_ex),
        .i_ex_mem   (ex_mem),
        .i_wb       (wb),
        .o_fwd_a    (fwd_a),
        .o_fwd_b    (fwd_b),
        .o_load_use (load_use)
    );

endmodule

// File: verification/rv_core_sva.sv
`timescale 1ns/1ps

module rv_core_sva (
    input logic              clk,
    input logic              rst_n,
    input rv_pkg::dmem_req_t i_dmem,
    input logic              i_stall
);

    // one access per request
    never_both_enables: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_dmem.ren && i_dmem.wen))
        else $error("dmem read and write enables high together");

    request_held: assert property (@(posedge clk) disable iff (!rst_n)
        i_stall |=> $stable(i_dmem))
        else $error("dmem request changed while stalled");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!i_dmem.ren && !i_dmem.wen))
        else $error("dmem enable high during reset");

endmodule

bind rv_core rv_core_sva sva_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_dmem  (o_dmem),
    .i_stall (i_dmem_stall)
);

// File: verification/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int PROG_LEN   = 60;
    localparam int DUMP_BASE  = 60;              // first register dump store
    localparam int LOOP_IDX   = DUMP_BASE + 31;  // jal to itself
    localparam int IMEM_WORDS = 128;
    localparam int DMEM_WORDS = 1024;
    localparam logic [11:0] WIN_BASE  = 12'h400;  // 16-word load/store window
    localparam logic [11:0] DUMP_ADDR = 12'h500;

    logic              clk;
    logic              rst_n;
    logic [XLEN-1:0]   i_imem_rdata;
    logic [ADDR_W-1:0] o_imem_addr;
    dmem_req_t         o_dmem;
    logic [XLEN-1:0]   i_dmem_rdata;
    logic              i_dmem_stall;

    logic [31:0] lfsr;
    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    bit          written [DMEM_WORDS];
    logic [31:0] ref_mem [DMEM_WORDS];
    logic [31:0] ref_regs [32];
    logic [29:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          store_errors;
    int          check_errors;
    int          stores_seen;
    int          loads_seen;
    int          exp_loads;
    int          ref_steps;
    int          watchdog_cycles;
    logic        limit_set;

    rv_core dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_imem_rdata (i_imem_rdata),
        .o_imem_addr  (o_imem_addr),
        .o_dmem       (o_dmem),
        .i_dmem_rdata (i_dmem_rdata),
        .i_dmem_stall (i_dmem_stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    // unwritten words read the fill pattern
    assign i_imem_rdata = imem[o_imem_addr[6:0]];
    assign i_dmem_rdata = written[o_dmem.addr[9:0]] ? dmem[o_dmem.addr[9:0]] :
                          fill_word({2'b00, o_dmem.addr});

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32,22,2,1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_RTYPE};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE};  // base is x0
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // ISA semantics of the register and immediate ALU forms
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return {31'd0, ($signed(x) < $signed(y))};
            3'b100:  return x ^ y;
            3'b101:  return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            3'b111:  return x & y;
            default: return x + y;
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] kind;
        logic [31:0] v;
        logic [31:0] off;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  sel;
        int          k;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP_INST;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            take_bits(4, kind);
            take_bits(5, v);
            rd = v[4:0];
            take_bits(5, v);
            rs1 = v[4:0];
            take_bits(5, v);
            rs2 = v[4:0];
            take_bits(4, off);
            take_bits(12, imm);
            take_bits(4, v);
            sel = v[3:0];
            k = int'(off[2:0]) + 1;  // forward only and never past the dump
            if (i + k > DUMP_BASE)
                k = DUMP_BASE - i;
            if (kind[3:0] < 4'd5) begin
                if (sel > 4'd8)
                    sel = sel - 4'd7;
                case (sel)
                    4'd0: imem[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
                    4'd1: imem[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
                    4'd2: imem[i] = enc_r(7'h00, rs2, rs1, 3'b001, rd);
                    4'd3: imem[i] = enc_r(7'h00, rs2, rs1, 3'b010, rd);
                    4'd4: imem[i] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
                    4'd5: imem[i] = enc_r(7'h00, rs2, rs1, 3'b101, rd);
                    4'd6: imem[i] = enc_r(7'h20, rs2, rs1, 3'b101, rd);
                    4'd7: imem[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
                    default: imem[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
                endcase
            end else if (kind[3:0] < 4'd10) begin
                case (sel[2:0])
                    3'd0: imem[i] = enc_i(imm[11:0], rs1, 3'b000, rd, OP_ITYPE);
                    3'd1: imem[i] = enc_i(imm[11:0], rs1, 3'b010, rd, OP_ITYPE);
                    3'd2: imem[i] = enc_i(imm[11:0], rs1, 3'b100, rd, OP_ITYPE);
                    3'd3: imem[i] = enc_i(imm[11:0], rs1, 3'b110, rd, OP_ITYPE);
                    3'd4: imem[i] = enc_i(imm[11:0], rs1, 3'b111, rd, OP_ITYPE);
                    3'd5: imem[i] = enc_i({7'h00, imm[4:0]}, rs1, 3'b001, rd, OP_ITYPE);
                    3'd6: imem[i] = enc_i({7'h00, imm[4:0]}, rs1, 3'b101, rd, OP_ITYPE);
                    default: imem[i] = enc_i({7'h20, imm[4:0]}, rs1, 3'b101, rd, OP_ITYPE);
                endcase
            end else if (kind[3:0] < 4'd12) begin
                imem[i] = enc_i(WIN_BASE + {6'd0, off[3:0], 2'b00}, 5'd0, 3'b010, rd, OP_LOAD);
            end else if (kind[3:0] < 4'd14) begin
                imem[i] = enc_s(WIN_BASE + {6'd0, off[3:0], 2'b00}, rs2);
            end else if (kind[3:0] == 4'd14) begin
                imem[i] = enc_b(13'(k * 4), rs2, rs1, {2'b00, sel[0]});  // beq or bne
            end else begin
                imem[i] = enc_j(21'(k * 4), rd);
            end
        end
        for (int r = 1; r < 32; r++) begin
            imem[DUMP_BASE + r - 1] = enc_s(DUMP_ADDR + 12'(r * 4), 5'(r));
        end
        imem[LOOP_IDX] = enc_j(21'd0, 5'd0);
    endtask

    // interpreter that records the ordered store list and counts loads
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] next;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] ea;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [4:0]  rd;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ref_mem[i] = fill_word(32'(i));
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        pc = '0;
        ref_steps = 0;
        exp_loads = 0;
        while (pc != 32'(LOOP_IDX * 4) && ref_steps < 10000) begin
            w     = imem[pc[8:2]];
            rd    = w[11:7];
            a     = ref_regs[w[19:15]];
            b     = ref_regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            next  = pc + 32'd4;
            res   = 'x;
            case (w[6:0])
                OP_RTYPE: res = alu_ref(w[14:12], w[30], a, b);
                OP_ITYPE: res = alu_ref(w[14:12], w[14:12] == 3'b101 && w[30], a, imm_i);
                OP_LOAD: begin
                    ea  = a + imm_i;
                    res = ref_mem[ea[11:2]];
                    exp_loads++;
                end
                OP_STORE: begin
                    ea = a + imm_s;
                    ref_mem[ea[11:2]] = b;
                    exp_addr.push_back(ea[31:2]);
                    exp_data.push_back(b);
                end
                OP_BRANCH: begin
                    if ((a == b) != w[12])
                        next = pc + imm_b;
                end
                OP_JAL: begin
                    res  = pc + 32'd4;
                    next = pc + imm_j;
                end
                default: ;
            endcase
            if (rd != 5'd0 && w[6:0] != OP_STORE && w[6:0] != OP_BRANCH)
                ref_regs[rd] = res;
            pc = next;
            ref_steps++;
        end
    endtask

    task automatic check_reset_outputs(input string where);
        assert (o_imem_addr == '0 && !o_dmem.ren && !o_dmem.wen) else begin
            check_errors++;
            $display("error %s: expected addr 0 ren 0 wen 0, actual addr %h ren %b wen %b",
                     where, o_imem_addr, o_dmem.ren, o_dmem.wen);
        end
    endtask

    // data memory writes, in-order store check and read count
    always @(posedge clk) begin
        if (rst_n && o_dmem.ren && !i_dmem_stall) begin
            loads_seen++;
        end
        if (rst_n && o_dmem.wen && !i_dmem_stall) begin
            assert (stores_seen < exp_addr.size()) else begin
                store_errors++;
                $display("store beyond the expected list, word address %h", o_dmem.addr);
            end
            if (stores_seen < exp_addr.size()) begin
                assert (o_dmem.addr == exp_addr[stores_seen] &&
                        o_dmem.wdata == exp_data[stores_seen]) else begin
                    store_errors++;
                    $display({"error store_check[%0d]: expected addr %h data %h, ",
                              "actual addr %h data %h"},
                             stores_seen, exp_addr[stores_seen], exp_data[stores_seen],
                             o_dmem.addr, o_dmem.wdata);
                end
            end
            dmem[o_dmem.addr[9:0]]    <= o_dmem.wdata;
            written[o_dmem.addr[9:0]] <= 1'b1;
            stores_seen++;
        end
    end

    initial begin : watchdog
        wait (limit_set);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: program did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main_seq
        logic [31:0] v;
        rst_n        = 1'b0;
        i_dmem_stall = 1'b0;
        lfsr         = 32'h2bae_a048;
        check_errors = 0;
        limit_set    = 1'b0;
        build_program();
        run_model();
        // four cycles per instruction, two more for stalls and a fixed margin
        watchdog_cycles = ref_steps * 4 + ref_steps * 2 + 300;
        limit_set = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_reset_outputs("reset_check");
        end
        rst_n = 1'b1;
        #1;
        check_reset_outputs("post_reset_check");
        while (stores_seen < exp_addr.size()) begin
            @(negedge clk);
            take_bits(2, v);
            i_dmem_stall = (v[1:0] == 2'b11);  // about one cycle in four
        end
        @(negedge clk);
        i_dmem_stall = 1'b0;
        repeat (10) @(negedge clk);
        repeat (10) begin
            @(negedge clk);
            assert (o_imem_addr == 30'(LOOP_IDX)) else begin
                check_errors++;
                $display("error loop_check: expected addr %h, actual addr %h",
                         30'(LOOP_IDX), o_imem_addr);
            end
        end
        assert (stores_seen == exp_addr.size()) else begin
            check_errors++;
            $display("error store_count: expected %0d, actual %0d", exp_addr.size(), stores_seen);
        end
        assert (loads_seen == exp_loads) else begin
            check_errors++;
            $display("error load_count: expected %0d, actual %0d", exp_loads, loads_seen);
        end
        $display("store errors %0d, other errors %0d, stores %0d of %0d, model steps %0d",
                 store_errors, check_errors, stores_seen, exp_addr.size(), ref_steps);
        if (store_errors + check_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
source/rv_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_unit.sv
source/rv_core.sv
verification/rv_core_sva.sv
verification/tb_rv_core.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -f project.f --top-module tb_rv_core -o sim_tb_rv_core
./obj_dir/sim_tb_rv_core > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    exit 1
fi
